// File: perm_consts.svh
`ifndef PERM_CONSTS_SVH
`define PERM_CONSTS_SVH

// datapath shape
`define PERM_LANES 32
`define PERM_LANE_W 16
`define PERM_STAGES 9

// one control bit per 2x2 switch, 16 switches per stage
`define PERM_CTRL_W 144

`define PERM_SLOTS 4
`define PERM_TAG_W 8

// input buffer depth, equal to the sender's starting credits
`define PERM_IN_DEPTH 4

// credits granted by the sink after reset
`define PERM_OUT_CREDITS 4

`endif

// File: perm_pkg.sv
`default_nettype none

`include "perm_consts.svh"

package perm_pkg;

    typedef enum logic [1:0] {
        OP_NOP      = 2'd0,
        OP_LOAD_CFG = 2'd1,
        OP_PERMUTE  = 2'd2
    } perm_op_t;

    typedef logic [`PERM_LANES-1:0][`PERM_LANE_W-1:0] lane_vec_t;

    // travels beside the lanes through every pipeline register
    typedef struct packed {
        logic                   valid;
        logic [`PERM_TAG_W-1:0] tag;
    } perm_meta_t;

    typedef struct packed {
        perm_op_t               op;
        logic [1:0]             slot;
        logic [`PERM_TAG_W-1:0] tag;
        lane_vec_t              lanes;
    } perm_beat_t;

    typedef struct packed {
        logic [`PERM_TAG_W-1:0] tag;
        lane_vec_t              lanes;
    } perm_out_t;

    typedef logic [`PERM_CTRL_W-1:0] benes_ctrl_t;

endpackage

`default_nettype wire

// File: perm_in_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "perm_consts.svh"

module perm_in_fifo import perm_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       in_valid,
    input  perm_beat_t in_beat,
    input  logic       pop,
    output logic       head_valid,
    output perm_beat_t head_beat,
    output logic       in_credit
);

    localparam int PTR_W = $clog2(`PERM_IN_DEPTH);
    localparam int CNT_W = $clog2(`PERM_IN_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(`PERM_IN_DEPTH);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(`PERM_IN_DEPTH - 1);

    perm_beat_t       mem [`PERM_IN_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge CLK) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            count     <= count + CNT_W'(in_valid) - CNT_W'(pop);
            // one credit back per released entry
            in_credit <= pop;
        end
    end

    assign head_valid = (count != '0);
    assign head_beat  = mem[rd_ptr];

    // sender must respect its credits
    a_no_overflow: assert property (@(posedge CLK) disable iff (!nRST)
        in_valid |-> (count != FULL))
        else $error("input buffer written while full");

    a_no_underflow: assert property (@(posedge CLK) disable iff (!nRST)
        pop |-> head_valid)
        else $error("input buffer popped while empty");

endmodule

`default_nettype wire

// File: benes_cfg_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "perm_consts.svh"

module benes_cfg_store import perm_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        cfg_we,
    input  logic [1:0]  cfg_slot,
    input  benes_ctrl_t cfg_data,
    input  logic [1:0]  rd_slot,
    output benes_ctrl_t rd_ctrl
);

    benes_ctrl_t slots [`PERM_SLOTS];

    // all-zero setting is the identity permutation
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `PERM_SLOTS; i++) begin
                slots[i] <= '0;
            end
        end else if (cfg_we) begin
            slots[cfg_slot] <= cfg_data;
        end
    end

    // combinational read, new value visible the cycle after the write
    assign rd_ctrl = slots[rd_slot];

endmodule

`default_nettype wire

// File: perm_issue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "perm_consts.svh"

module perm_issue_ctrl import perm_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        head_valid,
    input  perm_beat_t  head_beat,
    input  logic        out_credit,
    output logic        pop,
    output logic        cfg_we,
    output logic [1:0]  cfg_slot,
    output benes_ctrl_t cfg_data,
    output logic [1:0]  rd_slot,
    output perm_meta_t  net_meta,
    output lane_vec_t   net_lanes
);

    localparam int CR_W = $clog2(`PERM_OUT_CREDITS + 1);
    localparam logic [CR_W-1:0] CR_MAX = CR_W'(`PERM_OUT_CREDITS);

    logic [CR_W-1:0] credit_cnt;
    logic            has_credit;
    logic            issue;

    assign has_credit = (credit_cnt != '0);

    // decode the head beat
    always_comb begin
        pop    = 1'b0;
        cfg_we = 1'b0;
        issue  = 1'b0;
        if (head_valid) begin
            case (head_beat.op)
                OP_LOAD_CFG: begin
                    pop    = 1'b1;
                    cfg_we = 1'b1;
                end
                OP_PERMUTE: begin
                    // wait in the buffer until the sink has room
                    pop   = has_credit;
                    issue = has_credit;
                end
                default: begin
                    pop = 1'b1;
                end
            endcase
        end
    end

    // lane k holds control bits 16k..16k+15
    always_comb begin
        cfg_data = '0;
        for (int k = 0; k < `PERM_STAGES; k++) begin
            cfg_data[k*`PERM_LANE_W +: `PERM_LANE_W] = head_beat.lanes[k];
        end
    end

    assign cfg_slot       = head_beat.slot;
    assign rd_slot        = head_beat.slot;
    assign net_meta.valid = issue;
    assign net_meta.tag   = head_beat.tag;
    assign net_lanes      = head_beat.lanes;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            credit_cnt <= CR_MAX;
        end else if (issue && !out_credit) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (out_credit && !issue) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    // sink returns no more credits than it granted
    a_credit_max: assert property (@(posedge CLK) disable iff (!nRST)
        credit_cnt <= CR_MAX)
        else $error("output credit count above grant");

endmodule

`default_nettype wire

// File: benes_network.sv
`timescale 1ns/1ps
`default_nettype none

`include "perm_consts.svh"

module benes_network import perm_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,
    input  perm_meta_t  in_meta,
    input  lane_vec_t   in_lanes,
    input  benes_ctrl_t ctrl,
    output perm_meta_t  out_meta,
    output lane_vec_t   out_lanes
);

    // switches per stage
    localparam int SW   = `PERM_LANES / 2;
    localparam int HALF = `PERM_STAGES / 2;

    genvar s, p;

    generate
        for (s = 0; s < `PERM_STAGES; s++) begin : g_stage
            // distances 1,2,4,8,16,8,4,2,1
            localparam int LOG_D = (s <= HALF) ? s : (`PERM_STAGES - 1 - s);
            localparam int DIST  = 1 << LOG_D;
            // control still unused when the beat reaches this stage
            localparam int CW    = `PERM_CTRL_W - SW * s;

            lane_vec_t       in_l;
            perm_meta_t      in_m;
            logic [CW-1:0]   in_c;
            lane_vec_t       out_l;

            if (s == 0) begin : g_src
                assign in_l = in_lanes;
                assign in_m = in_meta;
                assign in_c = ctrl;
            end else begin : g_src
                // register between stage s-1 and stage s
                always_ff @(posedge CLK or negedge nRST) begin
                    if (!nRST) begin
                        in_l <= '0;
                        in_m <= '0;
                        in_c <= '0;
                    end else begin
                        in_l <= g_stage[s-1].out_l;
                        in_m <= g_stage[s-1].in_m;
                        in_c <= g_stage[s-1].in_c[CW+SW-1:SW];
                    end
                end
            end

            for (p = 0; p < SW; p++) begin : g_pair
                // insert a zero at bit LOG_D of the rank to get the lower lane
                localparam int LO = ((p >> LOG_D) << (LOG_D + 1)) | (p & (DIST - 1));
                localparam int HI = LO + DIST;

                assign out_l[LO] = in_c[p] ? in_l[HI] : in_l[LO];
                assign out_l[HI] = in_c[p] ? in_l[LO] : in_l[HI];
            end
        end
    endgenerate

    // last stage is combinational after the final register
    assign out_lanes = g_stage[`PERM_STAGES-1].out_l;
    assign out_meta  = g_stage[`PERM_STAGES-1].in_m;

endmodule

`default_nettype wire

// File: perm_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module perm_unit_top import perm_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       in_valid,
    input  perm_beat_t in_beat,
    output logic       in_credit,
    output logic       out_valid,
    output perm_out_t  out_beat,
    input  logic       out_credit
);

    logic        head_valid;
    perm_beat_t  head_beat;
    logic        pop;
    logic        cfg_we;
    logic [1:0]  cfg_slot;
    benes_ctrl_t cfg_data;
    logic [1:0]  rd_slot;
    benes_ctrl_t rd_ctrl;
    perm_meta_t  net_meta;
    lane_vec_t   net_lanes;
    perm_meta_t  res_meta;
    lane_vec_t   res_lanes;

    perm_in_fifo i_in_fifo (
        .CLK        (CLK),
        .nRST       (nRST),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .pop        (pop),
        .head_valid (head_valid),
        .head_beat  (head_beat),
        .in_credit  (in_credit)
    );

    benes_cfg_store i_cfg_store (
        .CLK      (CLK),
        .nRST     (nRST),
        .cfg_we   (cfg_we),
        .cfg_slot (cfg_slot),
        .cfg_data (cfg_data),
        .rd_slot  (rd_slot),
        .rd_ctrl  (rd_ctrl)
    );

    perm_issue_ctrl i_issue_ctrl (
        .CLK        (CLK),
        .nRST       (nRST),
        .head_valid (head_valid),
        .head_beat  (head_beat),
        .out_credit (out_credit),
        .pop        (pop),
        .cfg_we     (cfg_we),
        .cfg_slot   (cfg_slot),
        .cfg_data   (cfg_data),
        .rd_slot    (rd_slot),
        .net_meta   (net_meta),
        .net_lanes  (net_lanes)
    );

    // setting for the issued beat comes straight from the store read port
    benes_network i_network (
        .CLK       (CLK),
        .nRST      (nRST),
        .in_meta   (net_meta),
        .in_lanes  (net_lanes),
        .ctrl      (rd_ctrl),
        .out_meta  (res_meta),
        .out_lanes (res_lanes)
    );

    assign out_valid      = res_meta.valid;
    assign out_beat.tag   = res_meta.tag;
    assign out_beat.lanes = res_lanes;

endmodule

`default_nettype wire

// File: tb_perm_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "perm_consts.svh"

module tb_perm_unit import perm_pkg::*; ();

    localparam int NUM_TESTS   = 5;
    localparam int TEST_CYCLES = 200;
    localparam int SLICE       = `PERM_CTRL_W / `PERM_STAGES;
    localparam int OUT_W       = $bits(perm_out_t);

    logic       CLK;
    logic       nRST;
    logic       in_valid;
    perm_beat_t in_beat;
    logic       in_credit;
    logic       out_valid;
    perm_out_t  out_beat;
    logic       out_credit;

    logic [31:0] lfsr_state = 32'hedc9_00be;
    benes_ctrl_t shadow [`PERM_SLOTS];
    perm_out_t   exp_q [$];
    int          snd_credits = `PERM_IN_DEPTH;
    int          beats_sent = 0;
    int          credit_pulses = 0;
    int          out_cnt = 0;
    int          sink_owed = 0;
    logic        sink_on = 1'b1;
    int          checks = 0;
    int          errors = 0;
    int          tests_run = 0;

    perm_unit_top i_dut (
        .CLK        (CLK),
        .nRST       (nRST),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_beat   (out_beat),
        .out_credit (out_credit)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial begin
        #(NUM_TESTS * TEST_CYCLES * 10);
        $display("watchdog expired after %0d cycles, run stopped", NUM_TESTS * TEST_CYCLES);
        $display("Test failed");
        $finish;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic lane_vec_t random_lanes();
        lane_vec_t v;
        for (int i = 0; i < $bits(lane_vec_t); i++) begin
            v[i / `PERM_LANE_W][i % `PERM_LANE_W] = next_bit();
        end
        return v;
    endfunction

    function automatic benes_ctrl_t random_setting();
        benes_ctrl_t c;
        for (int i = 0; i < `PERM_CTRL_W; i++) begin
            c[i] = next_bit();
        end
        return c;
    endfunction

    // pairs ranked by lower lane and a set bit swaps the pair
    function automatic lane_vec_t benes_ref(lane_vec_t v, benes_ctrl_t c);
        lane_vec_t               r;
        logic [`PERM_LANE_W-1:0] t;
        int                      d;
        int                      rank;
        r = v;
        for (int s = 0; s < `PERM_STAGES; s++) begin
            d = (s <= `PERM_STAGES / 2) ? (1 << s) : (1 << (`PERM_STAGES - 1 - s));
            rank = 0;
            for (int i = 0; i < `PERM_LANES; i++) begin
                if ((i & d) == 0) begin
                    if (c[SLICE * s + rank]) begin
                        t = r[i];
                        r[i] = r[i + d];
                        r[i + d] = t;
                    end
                    rank++;
                end
            end
        end
        return r;
    endfunction

    function automatic perm_beat_t make_beat(perm_op_t op, logic [1:0] slot,
                                             logic [`PERM_TAG_W-1:0] tag, lane_vec_t v);
        perm_beat_t b;
        b.op    = op;
        b.slot  = slot;
        b.tag   = tag;
        b.lanes = v;
        return b;
    endfunction

    task automatic check_value(string name, logic [OUT_W-1:0] exp, logic [OUT_W-1:0] got);
        checks++;
        assert (got === exp) else begin
            $display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_count(string what, int exp, int got);
        checks++;
        assert (got == exp) else begin
            $display("at %0t ns: %s was %0d, should be %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic send_beat(perm_beat_t b);
        @(negedge CLK);
        in_valid = 1'b0;
        while (snd_credits == 0) begin
            @(negedge CLK);
        end
        in_valid = 1'b1;
        in_beat  = b;
        snd_credits--;
        beats_sent++;
    endtask

    task automatic finish_send();
        @(negedge CLK);
        in_valid = 1'b0;
    endtask

    task automatic load_slot(logic [1:0] slot, benes_ctrl_t setting);
        lane_vec_t v;
        v = random_lanes();
        for (int k = 0; k < `PERM_STAGES; k++) begin
            v[k] = setting[k * SLICE +: SLICE];
        end
        shadow[slot] = setting;
        send_beat(make_beat(OP_LOAD_CFG, slot, '0, v));
    endtask

    task automatic permute(logic [1:0] slot, logic [`PERM_TAG_W-1:0] tag);
        lane_vec_t v;
        v = random_lanes();
        exp_q.push_back('{tag: tag, lanes: benes_ref(v, shadow[slot])});
        send_beat(make_beat(OP_PERMUTE, slot, tag, v));
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || (sink_on && sink_owed != 0)) && n < TEST_CYCLES) begin
            @(posedge CLK);
            n++;
        end
        checks++;
        assert (exp_q.size() == 0) else begin
            $display("at %0t ns: %0d expected outputs never arrived", $time, exp_q.size());
            errors++;
        end
    endtask

    task automatic report_test(string name, int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic test_reset_identity();
        int        e0;
        lane_vec_t v;
        e0 = errors;
        check_value("out_valid", 1'b0, out_valid);
        check_value("in_credit", 1'b0, in_credit);
        // slot 0 still holds zero so lanes come back untouched
        v = random_lanes();
        exp_q.push_back('{tag: 8'h11, lanes: v});
        send_beat(make_beat(OP_PERMUTE, 2'd0, 8'h11, v));
        finish_send();
        wait_drain();
        report_test("reset and identity", e0);
    endtask

    task automatic test_configured();
        int e0;
        e0 = errors;
        for (int s = 0; s < `PERM_SLOTS; s++) begin
            load_slot(2'(s), random_setting());
            permute(2'(s), 8'(8'h20 + 2 * s));
            permute(2'(s), 8'(8'h21 + 2 * s));
        end
        finish_send();
        wait_drain();
        report_test("configured permutation", e0);
    endtask

    task automatic test_in_flight();
        int e0;
        e0 = errors;
        for (int s = 0; s < `PERM_SLOTS; s++) begin
            load_slot(2'(s), random_setting());
        end
        for (int i = 0; i < 8; i++) begin
            permute(2'(i % `PERM_SLOTS), 8'(8'h30 + i));
        end
        finish_send();
        wait_drain();
        report_test("settings in flight", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        int base;
        int n;
        e0 = errors;
        base = out_cnt;
        sink_on = 1'b0;
        for (int i = 0; i < 2 * `PERM_OUT_CREDITS; i++) begin
            permute(2'(i % `PERM_SLOTS), 8'(8'h40 + i));
        end
        finish_send();
        n = 0;
        while (out_cnt - base < `PERM_OUT_CREDITS && n < TEST_CYCLES / 2) begin
            @(posedge CLK);
            n++;
        end
        // nothing more may show up well past the network latency
        repeat (20) @(posedge CLK);
        check_count("outputs without returned credits", `PERM_OUT_CREDITS, out_cnt - base);
        sink_on = 1'b1;
        wait_drain();
        check_count("outputs after credits returned", 2 * `PERM_OUT_CREDITS, out_cnt - base);
        report_test("output back-pressure", e0);
    endtask

    task automatic test_input_credits();
        int e0;
        int sent0;
        int pulses0;
        int out0;
        int n;
        e0 = errors;
        sent0 = beats_sent;
        pulses0 = credit_pulses;
        out0 = out_cnt;
        load_slot(2'd1, random_setting());
        send_beat(make_beat(OP_NOP, 2'd0, 8'h50, random_lanes()));
        permute(2'd1, 8'h51);
        send_beat(make_beat(OP_NOP, 2'd2, 8'h52, random_lanes()));
        send_beat(make_beat(OP_NOP, 2'd3, 8'h53, random_lanes()));
        load_slot(2'd2, random_setting());
        permute(2'd2, 8'h54);
        permute(2'd1, 8'h55);
        send_beat(make_beat(OP_NOP, 2'd1, 8'h56, random_lanes()));
        finish_send();
        wait_drain();
        n = 0;
        while (snd_credits != `PERM_IN_DEPTH && n < TEST_CYCLES / 2) begin
            @(posedge CLK);
            n++;
        end
        check_count("in_credit pulses", beats_sent - sent0, credit_pulses - pulses0);
        check_count("outputs from mixed beats", 3, out_cnt - out0);
        report_test("input credits", e0);
    endtask

    initial begin : out_monitor
        perm_out_t expected;
        forever begin
            @(posedge CLK);
            #2;
            if (in_credit) begin
                snd_credits++;
                credit_pulses++;
                checks++;
                assert (snd_credits <= `PERM_IN_DEPTH) else begin
                    $display("at %0t ns: in_credit returned a credit for no outstanding beat",
                             $time);
                    errors++;
                end
            end
            if (out_valid) begin
                out_cnt++;
                sink_owed++;
                assert (exp_q.size() != 0) else begin
                    $display("at %0t ns: output with tag %0h arrived when none was expected",
                             $time, out_beat.tag);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    expected = exp_q.pop_front();
                    check_value("out_beat", expected, out_beat);
                end
            end
        end
    end

    // returns one credit per output received while enabled
    initial begin : credit_sink
        out_credit = 1'b0;
        forever begin
            @(negedge CLK);
            if (sink_on && sink_owed > 0) begin
                out_credit = 1'b1;
                sink_owed--;
            end else begin
                out_credit = 1'b0;
            end
        end
    end

    initial begin
        nRST     = 1'b0;
        in_valid = 1'b0;
        in_beat  = '0;
        for (int s = 0; s < `PERM_SLOTS; s++) begin
            shadow[s] = '0;
        end
        repeat (2) @(negedge CLK);
        nRST = 1'b1;
        test_reset_identity();
        test_configured();
        test_in_flight();
        test_backpressure();
        test_input_credits();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
perm_pkg.sv
perm_in_fifo.sv
benes_cfg_store.sv
perm_issue_ctrl.sv
benes_network.sv
perm_unit_top.sv
tb_perm_unit.sv

// File: run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_perm_unit -o tb_perm_unit \
    && ./obj_dir/tb_perm_unit > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
